/* netfifo_defines.svh */
`ifndef NETFIFO_DEFINES_SVH
`define NETFIFO_DEFINES_SVH

//////////////////////////////////////////////////
// Packet FIFO geometry
//////////////////////////////////////////////////

// Bits per data beat
`define NETFIFO_BW 8

// log2 of FIFO depth, 16 entries
`define NETFIFO_LGFLEN 4

`endif

/* src/netfifo_pkg.sv */
`include "netfifo_defines.svh"

package netfifo_pkg;

	//////////////////////////////////////////////////
	// Types shared by the three stages
	//////////////////////////////////////////////////

	// One beat of packet payload
	typedef logic [`NETFIFO_BW-1:0] beat_data_t;

	// Read, write and end-of-packet pointers
	// Extra top bit tells full from empty
	typedef logic [`NETFIFO_LGFLEN:0] fifo_ptr_t;

	// Storage index, low part of a pointer
	typedef logic [`NETFIFO_LGFLEN-1:0] ram_addr_t;

	// Stored word, last flag above the beat
	typedef logic [`NETFIFO_BW:0] store_entry_t;

endpackage

/* src/pkt_write_admit.sv */
`include "netfifo_defines.svh"

module pkt_write_admit (
	input  wire                       S_AXI_ACLK,
	input  wire                       S_AXI_ARESETN,
	// Input stream
	input  wire                       s_axin_valid,
	output logic                      s_axin_ready,
	input  netfifo_pkg::beat_data_t   s_axin_data,
	input  wire                       s_axin_last,
	input  wire                       s_axin_abort,
	// Egress side
	input  netfifo_pkg::fifo_ptr_t    rd_ptr,
	input  wire                       pop,
	input  wire                       m_axin_valid,
	// Write pointer and storage write port
	output netfifo_pkg::fifo_ptr_t    wr_ptr,
	output logic                      store_wen,
	output netfifo_pkg::ram_addr_t    store_waddr,
	output netfifo_pkg::store_entry_t store_wdata,
	// Packet end status
	output logic                      lastv,
	output logic                      drop_unsent
);

	// Accepted beat
	logic w_wr;
	// Abort that hits a packet in progress
	logic s_abort;
	// Accepted beat that closes a packet
	logic wr_eop;
	// Input currently inside a packet
	logic s_midpacket;
	// Pointer of newest stored packet end
	netfifo_pkg::fifo_ptr_t eop_ptr;
	// Stored packet end is the entry on show
	logic eop_next;
	// Occupancy
	netfifo_pkg::fifo_ptr_t fill;
	logic full;

	//////////////////////////////////////////////////
	// Handshake decode
	//////////////////////////////////////////////////

	// Abort beats never go into storage
	assign w_wr = s_axin_valid && s_axin_ready && !s_axin_abort;
	assign wr_eop = w_wr && s_axin_last;

	// Only counts between first beat and last beat
	assign s_abort = s_axin_abort && s_midpacket;

	// Fill level from own write pointer and egress read pointer
	assign fill = wr_ptr - rd_ptr;
	assign full = fill[`NETFIFO_LGFLEN];

	// Abort is always taken, even when full
	always_comb
	begin
		if (s_axin_abort)
			s_axin_ready = 1'b1;
		else
			s_axin_ready = !full;
	end

	// Input packet progress
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			s_midpacket <= 1'b0;
		else if (s_axin_abort)
			s_midpacket <= 1'b0;
		else if (s_axin_valid && s_axin_ready)
			s_midpacket <= !s_axin_last;
	end

	//////////////////////////////////////////////////
	// End-of-packet tracking
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			eop_ptr <= '0;
		else if (wr_eop)
			eop_ptr <= wr_ptr;
	end

	assign eop_next = lastv && (eop_ptr == rd_ptr);

	// Held until egress pops the end entry
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			lastv <= 1'b0;
		else if (wr_eop)
			lastv <= 1'b1;
		else if (pop && eop_next)
			lastv <= 1'b0;
	end

	// Partial packet with nothing complete behind it
	assign drop_unsent = s_abort && !lastv;

	//////////////////////////////////////////////////
	// Write pointer and rewind
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_ptr <= '0;
		else if (s_abort)
		begin
			if (lastv)
				// Back up to just after last full packet
				wr_ptr <= eop_ptr + 1'b1;
			else
				// Keep only the beat now on show
				wr_ptr <= rd_ptr + netfifo_pkg::fifo_ptr_t'(m_axin_valid);
		end
		else if (w_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// Storage write port
	assign store_wen = w_wr;
	assign store_waddr = wr_ptr[`NETFIFO_LGFLEN-1:0];
	assign store_wdata = {s_axin_last, s_axin_data};

endmodule

/* src/pkt_store_ram.sv */
`include "netfifo_defines.svh"

module pkt_store_ram (
	input  wire                       S_AXI_ACLK,
	// Write port
	input  wire                       store_wen,
	input  netfifo_pkg::ram_addr_t    store_waddr,
	input  netfifo_pkg::store_entry_t store_wdata,
	// Read port
	input  netfifo_pkg::ram_addr_t    store_raddr,
	output netfifo_pkg::store_entry_t store_rdata
);

	//////////////////////////////////////////////////
	// Packet storage array
	//////////////////////////////////////////////////

	// One entry per FIFO slot
	netfifo_pkg::store_entry_t mem [0:(1<<`NETFIFO_LGFLEN)-1];

	// Single write port
	// Beat lands on the edge it is accepted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (store_wen)
			mem[store_waddr] <= store_wdata;
	end

	// Asynchronous read
	// Head entry shows in the same cycle the read pointer moves
	assign store_rdata = mem[store_raddr];

endmodule

/* src/pkt_read_egress.sv */
`include "netfifo_defines.svh"

module pkt_read_egress (
	input  wire                       S_AXI_ACLK,
	input  wire                       S_AXI_ARESETN,
	// Admission side
	input  netfifo_pkg::fifo_ptr_t    wr_ptr,
	input  wire                       drop_unsent,
	output netfifo_pkg::fifo_ptr_t    rd_ptr,
	output logic                      pop,
	// Storage read port
	output netfifo_pkg::ram_addr_t    store_raddr,
	input  netfifo_pkg::store_entry_t store_rdata,
	// Output stream
	output logic                      m_axin_valid,
	input  wire                       m_axin_ready,
	output netfifo_pkg::beat_data_t   m_axin_data,
	output logic                      m_axin_last,
	output logic                      m_axin_abort
);

	// Pointers equal
	logic empty;
	// Output currently inside a packet
	logic r_midpacket;
	// Receiver takes the abort this cycle
	logic abort_done;

	//////////////////////////////////////////////////
	// Read side flow control
	//////////////////////////////////////////////////

	assign empty = (wr_ptr == rd_ptr);
	assign m_axin_valid = !empty;
	assign pop = m_axin_valid && m_axin_ready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_ptr <= '0;
		else if (pop)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Head entry straight from storage
	assign store_raddr = rd_ptr[`NETFIFO_LGFLEN-1:0];
	assign {m_axin_last, m_axin_data} = store_rdata;

	//////////////////////////////////////////////////
	// Output abort
	//////////////////////////////////////////////////

	// Abort is consumed when idle or ready
	assign abort_done = m_axin_abort && (!m_axin_valid || m_axin_ready);

	// Set once a packet starts to leave
	// Stays set through a stall on any beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_midpacket <= 1'b0;
		else if (abort_done)
			// Abort ends the packet at the receiver
			r_midpacket <= 1'b0;
		else if (m_axin_valid)
			r_midpacket <= !m_axin_ready || !m_axin_last;
	end

	// Raised only if something of the dropped packet is visible
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			m_axin_abort <= 1'b0;
		else if (!m_axin_abort)
			m_axin_abort <= drop_unsent && (m_axin_valid || r_midpacket);
		else if (abort_done)
			m_axin_abort <= 1'b0;
	end

endmodule

/* src/netfifo_top.sv */
module netfifo_top (
	input  wire                     S_AXI_ACLK,
	input  wire                     S_AXI_ARESETN,
	// Input stream
	input  wire                     s_axin_valid,
	output logic                    s_axin_ready,
	input  netfifo_pkg::beat_data_t s_axin_data,
	input  wire                     s_axin_last,
	input  wire                     s_axin_abort,
	// Output stream
	output logic                    m_axin_valid,
	input  wire                     m_axin_ready,
	output netfifo_pkg::beat_data_t m_axin_data,
	output logic                    m_axin_last,
	output logic                    m_axin_abort
);

	//////////////////////////////////////////////////
	// Stage interconnect
	//////////////////////////////////////////////////

	// FIFO pointers
	netfifo_pkg::fifo_ptr_t wr_ptr;
	netfifo_pkg::fifo_ptr_t rd_ptr;
	// Head entry taken
	logic pop;

	// Storage ports
	logic store_wen;
	netfifo_pkg::ram_addr_t store_waddr;
	netfifo_pkg::store_entry_t store_wdata;
	netfifo_pkg::ram_addr_t store_raddr;
	netfifo_pkg::store_entry_t store_rdata;

	// Mid-packet abort with no complete packet stored
	logic drop_unsent;

	// Admission
	// Packet end status stays inside admission
	pkt_write_admit u_write_admit (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axin_valid  (s_axin_valid),
		.s_axin_ready  (s_axin_ready),
		.s_axin_data   (s_axin_data),
		.s_axin_last   (s_axin_last),
		.s_axin_abort  (s_axin_abort),
		.rd_ptr        (rd_ptr),
		.pop           (pop),
		.m_axin_valid  (m_axin_valid),
		.wr_ptr        (wr_ptr),
		.store_wen     (store_wen),
		.store_waddr   (store_waddr),
		.store_wdata   (store_wdata),
		.lastv         (),
		.drop_unsent   (drop_unsent)
	);

	// Storage
	pkt_store_ram u_store_ram (
		.S_AXI_ACLK  (S_AXI_ACLK),
		.store_wen   (store_wen),
		.store_waddr (store_waddr),
		.store_wdata (store_wdata),
		.store_raddr (store_raddr),
		.store_rdata (store_rdata)
	);

	// Egress
	pkt_read_egress u_read_egress (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_ptr        (wr_ptr),
		.drop_unsent   (drop_unsent),
		.rd_ptr        (rd_ptr),
		.pop           (pop),
		.store_raddr   (store_raddr),
		.store_rdata   (store_rdata),
		.m_axin_valid  (m_axin_valid),
		.m_axin_ready  (m_axin_ready),
		.m_axin_data   (m_axin_data),
		.m_axin_last   (m_axin_last),
		.m_axin_abort  (m_axin_abort)
	);

endmodule

/* tb/netfifo_assertions.sv */
module netfifo_assertions (
	input  wire                     S_AXI_ACLK,
	input  wire                     S_AXI_ARESETN,
	input  wire                     s_axin_ready,
	input  wire                     s_axin_abort,
	input  wire                     m_axin_valid,
	input  wire                     m_axin_ready,
	input  netfifo_pkg::beat_data_t m_axin_data,
	input  wire                     m_axin_last,
	input  wire                     m_axin_abort
);

	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions, read by the testbench at the end of the run
	int fail_count = 0;

	//////////////////////////////////////////////////
	// Output stream protocol
	//////////////////////////////////////////////////

	// Stalled beat holds until taken
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		m_axin_valid && !m_axin_ready |=>
		m_axin_valid && $stable(m_axin_data) && $stable(m_axin_last))
	else
	begin
		$error("output beat changed while stalled");
		fail_count++;
	end

	// Idle output straight after reset
	assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !m_axin_valid && !m_axin_abort)
	else
	begin
		$error("output not idle after reset");
		fail_count++;
	end

	//////////////////////////////////////////////////
	// Input stream protocol
	//////////////////////////////////////////////////

	// Abort never back-pressured
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axin_abort |-> s_axin_ready)
	else
	begin
		$error("input ready low during abort");
		fail_count++;
	end

endmodule

bind netfifo_top netfifo_assertions u_assertions (
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.s_axin_ready  (s_axin_ready),
	.s_axin_abort  (s_axin_abort),
	.m_axin_valid  (m_axin_valid),
	.m_axin_ready  (m_axin_ready),
	.m_axin_data   (m_axin_data),
	.m_axin_last   (m_axin_last),
	.m_axin_abort  (m_axin_abort)
);

/* tb/netfifo_tb.sv */
`include "netfifo_defines.svh"

module netfifo_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS = 5;
	localparam int CYCLES_PER_TEST = 400;
	localparam int DEPTH = 1 << `NETFIFO_LGFLEN;
	// Cycles any single wait may take
	localparam int WAIT_LIMIT = 100;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic s_axin_valid;
	logic s_axin_ready;
	netfifo_pkg::beat_data_t s_axin_data;
	logic s_axin_last;
	logic s_axin_abort;
	logic m_axin_valid;
	logic m_axin_ready;
	netfifo_pkg::beat_data_t m_axin_data;
	logic m_axin_last;
	logic m_axin_abort;

	// Beats of complete packets, oldest first
	netfifo_pkg::store_entry_t exp_q[$];
	// Beats of the packet still being written
	netfifo_pkg::store_entry_t pend_q[$];

	string test_name;
	int value_errors;
	int other_errors;
	int assert_errors;
	// Output aborts taken by the receiver
	int aborts_seen;

	netfifo_top u_netfifo_top (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axin_valid  (s_axin_valid),
		.s_axin_ready  (s_axin_ready),
		.s_axin_data   (s_axin_data),
		.s_axin_last   (s_axin_last),
		.s_axin_abort  (s_axin_abort),
		.m_axin_valid  (m_axin_valid),
		.m_axin_ready  (m_axin_ready),
		.m_axin_data   (m_axin_data),
		.m_axin_last   (m_axin_last),
		.m_axin_abort  (m_axin_abort)
	);

	always #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;

	// Backstop for a stuck handshake
	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic expect_level(input string what, input logic want, input logic got);
		assert (got === want) else
		begin
			$display("ERR %s: %s expected %b, actual %b", test_name, what, want, got);
			value_errors++;
		end
	endtask

	task automatic expect_entry(input string what, input netfifo_pkg::store_entry_t want,
		input netfifo_pkg::store_entry_t got);
		assert (got === want) else
		begin
			$display("ERR %s: %s expected %h, actual %h", test_name, what, want, got);
			value_errors++;
		end
	endtask

	// Complete packets first, then what has leaked out of the open one
	task automatic take_output_beat();
		netfifo_pkg::store_entry_t want;
		assert (exp_q.size() + pend_q.size() > 0) else
		begin
			$display("%s: output beat appeared with nothing expected", test_name);
			other_errors++;
			return;
		end
		if (exp_q.size() > 0)
			want = exp_q.pop_front();
		else
			want = pend_q.pop_front();
		expect_entry("output beat {last,data}", want, {m_axin_last, m_axin_data});
	endtask

	// Output monitor, sampled mid-cycle where levels are settled
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			if (m_axin_abort && (!m_axin_valid || m_axin_ready))
				// Beat taken with the abort belongs to the dropped packet
				aborts_seen++;
			else if (m_axin_valid && m_axin_ready)
				take_output_beat();
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Called and returns 1 ns after a rising edge
	task automatic send_beat(input netfifo_pkg::beat_data_t data, input logic last);
		logic taken;
		int waited;
		taken = 1'b0;
		waited = 0;
		s_axin_valid = 1'b1;
		s_axin_data = data;
		s_axin_last = last;
		while (!taken && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			taken = s_axin_ready;
			@(posedge S_AXI_ACLK);
			#1;
			waited++;
		end
		s_axin_valid = 1'b0;
		assert (taken) else
		begin
			$display("%s: input never became ready for a beat", test_name);
			other_errors++;
		end
		if (taken)
		begin
			pend_q.push_back({last, data});
			// Packet closed, now owed to the output
			if (last)
			begin
				while (pend_q.size() > 0)
					exp_q.push_back(pend_q.pop_front());
			end
		end
	endtask

	task automatic send_packet(input int len);
		for (int i = 0; i < len; i++)
			send_beat(netfifo_pkg::beat_data_t'($urandom()), i == len - 1);
	endtask

	// One-cycle abort pulse
	task automatic abort_input();
		s_axin_abort = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		s_axin_abort = 1'b0;
		pend_q.delete();
	endtask

	task automatic wait_output_idle();
		logic idle;
		int waited;
		idle = 1'b0;
		waited = 0;
		while (!idle && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			idle = !m_axin_valid && !m_axin_abort;
			@(posedge S_AXI_ACLK);
			#1;
			waited++;
		end
		assert (idle) else
		begin
			$display("%s: output never went idle", test_name);
			other_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_single_packet();
		test_name = "single_packet";
		m_axin_ready = 1'b1;
		expect_level("m_axin_valid after reset", 1'b0, m_axin_valid);
		expect_level("m_axin_abort after reset", 1'b0, m_axin_abort);
		expect_level("s_axin_ready after reset", 1'b1, s_axin_ready);
		// Last flag only on beat 4, checked by the monitor
		send_packet(4);
		wait_output_idle();
	endtask

	task automatic test_random_packets();
		test_name = "random_packets";
		m_axin_ready = 1'b1;
		repeat (5)
			send_packet(1 + int'($urandom() % 6));
		wait_output_idle();
	endtask

	task automatic test_fill_stall();
		netfifo_pkg::store_entry_t head;
		test_name = "fill_stall";
		m_axin_ready = 1'b0;
		send_packet(DEPTH);
		head = exp_q[0];
		// Full FIFO, head beat parked
		repeat (4)
		begin
			@(negedge S_AXI_ACLK);
			expect_level("s_axin_ready when full", 1'b0, s_axin_ready);
			expect_level("m_axin_valid when full", 1'b1, m_axin_valid);
			expect_entry("held output beat", head, {m_axin_last, m_axin_data});
			@(posedge S_AXI_ACLK);
			#1;
		end
		m_axin_ready = 1'b1;
		wait_output_idle();
	endtask

	task automatic test_abort_keeps_complete();
		int aborts_before;
		test_name = "abort_keeps_complete";
		aborts_before = aborts_seen;
		m_axin_ready = 1'b0;
		send_packet(3);
		// Second packet cut after 3 beats
		repeat (3)
			send_beat(netfifo_pkg::beat_data_t'($urandom()), 1'b0);
		abort_input();
		repeat (2)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		m_axin_ready = 1'b1;
		wait_output_idle();
		assert (aborts_seen == aborts_before) else
		begin
			$display("ERR %s: output aborts expected %0d, actual %0d", test_name,
				aborts_before, aborts_seen);
			value_errors++;
		end
		send_packet(2);
		wait_output_idle();
	endtask

	task automatic test_abort_partial_sent();
		int aborts_before;
		int waited;
		logic seen;
		test_name = "abort_partial_sent";
		aborts_before = aborts_seen;
		m_axin_ready = 1'b1;
		// Open packet drains out before the abort
		repeat (3)
			send_beat(netfifo_pkg::beat_data_t'($urandom()), 1'b0);
		wait_output_idle();
		abort_input();
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < 6)
		begin
			@(negedge S_AXI_ACLK);
			seen = m_axin_abort;
			@(posedge S_AXI_ACLK);
			#1;
			waited++;
		end
		assert (seen) else
		begin
			$display("%s: output abort did not rise after the input abort", test_name);
			other_errors++;
		end
		wait_output_idle();
		assert (aborts_seen == aborts_before + 1) else
		begin
			$display("ERR %s: output aborts expected %0d, actual %0d", test_name,
				aborts_before + 1, aborts_seen);
			value_errors++;
		end
		send_packet(3);
		wait_output_idle();
	endtask

	//////////////////////////////////////////////////
	// Run
	//////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'hbcf9_07ac));
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		s_axin_valid = 1'b0;
		s_axin_data = '0;
		s_axin_last = 1'b0;
		s_axin_abort = 1'b0;
		m_axin_ready = 1'b0;
		value_errors = 0;
		other_errors = 0;
		assert_errors = 0;
		aborts_seen = 0;
		test_name = "reset";
		repeat (3) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		test_single_packet();
		test_random_packets();
		test_fill_stall();
		test_abort_keeps_complete();
		test_abort_partial_sent();

		test_name = "end_of_run";
		assert (exp_q.size() == 0) else
		begin
			$display("%s: %0d expected beats never came out", test_name, exp_q.size());
			other_errors++;
		end
		assert_errors = u_netfifo_top.u_assertions.fail_count;
		$display("Errors: value %0d, other %0d, assertion %0d", value_errors, other_errors,
			assert_errors);
		if (value_errors + other_errors + assert_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
src/netfifo_pkg.sv
src/pkt_write_admit.sv
src/pkt_store_ram.sv
src/pkt_read_egress.sv
src/netfifo_top.sv
tb/netfifo_assertions.sv
tb/netfifo_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	verilator --binary --assert -Wno-fatal --top-module netfifo_tb \
		-f tb.f -Mdir obj_dir -o vnetfifo_tb
	./obj_dir/vnetfifo_tb | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
